//--- hw/xv_pkg.sv
// word, register number, interrupt vector, VRAM request and fill command types

`default_nettype none

package xv_pkg;

    // VRAM word and width of every host register
    typedef logic [15:0] word_t;

    // host register numbers as seen on bus_reg_num_i
    typedef enum logic [3:0] {
        XM_INT_CTRL   = 4'd0,       // mask high byte, status/clear low byte
        XM_WR_INCR    = 4'd1,       // shared address increment
        XM_WR_ADDR    = 4'd2,       // VRAM write pointer
        XM_DATA       = 4'd3,       // VRAM data port
        XM_RD_ADDR    = 4'd4,       // VRAM read pointer
        XM_BLIT_DST   = 4'd5,       // fill start address
        XM_BLIT_VAL   = 4'd6,       // fill word
        XM_BLIT_COUNT = 4'd7,       // fill length whose write starts the fill
        XM_TIMER      = 4'd8,       // timer compare reloaded on write
        XM_SYS_CTRL   = 4'd9        // busy flags
    } xm_reg_e;

    // one bit per interrupt source with upper two unused
    typedef logic [3:0] intr_t;

    localparam int BLIT_INTR  = 0;  // fill done
    localparam int TIMER_INTR = 1;  // timer compare

    // one VRAM access from a requester
    typedef struct packed {
        logic  wr;                  // 1 = write, 0 = read
        word_t addr;                // word address wrapping at VRAM size
        word_t data;                // write data
    } mem_req_t;

    // block fill command
    typedef struct packed {
        word_t dst;                 // first address
        word_t val;                 // word stored at every address
        word_t count;               // number of words where 0 means nothing
    } blit_cmd_t;

endpackage

`default_nettype wire

//--- hw/vram_arb.sv
// VRAM word storage with fixed priority host and fill arbitration

`default_nettype none
`timescale 1ns/1ps

module vram_arb #(
    parameter int VRAM_AW = 10          // address bits for 2**VRAM_AW words
)(
    input  wire logic               clk,
    input  wire logic               host_sel_i,
    input  wire xv_pkg::mem_req_t   host_req_i,
    input  wire logic               blit_sel_i,
    input  wire xv_pkg::mem_req_t   blit_req_i,
    output logic                    host_ack_o,
    output logic                    blit_ack_o,
    output xv_pkg::word_t           rd_data_o   // valid in ack cycle
);

localparam int DEPTH = 2**VRAM_AW;

xv_pkg::word_t      mem [DEPTH];
logic               host_grant;
logic               blit_grant;
xv_pkg::mem_req_t   req;                // winning request
logic [VRAM_AW-1:0] idx;                // wrapped address

// a requester already acked this cycle is not served again
assign host_grant = host_sel_i & ~host_ack_o;
assign blit_grant = blit_sel_i & ~blit_ack_o & ~host_grant;   // host first

assign req = host_grant ? host_req_i : blit_req_i;
assign idx = req.addr[VRAM_AW-1:0];

always_ff @(posedge clk) begin
    host_ack_o <= host_grant;
    blit_ack_o <= blit_grant;
end

// access happens on the edge that raises ack
always_ff @(posedge clk) begin
    if (host_grant || blit_grant) begin
        if (req.wr) begin
            mem[idx] <= req.data;
        end
        rd_data_o <= mem[idx];          // old word on write
    end
end

endmodule

`default_nettype wire

//--- hw/blit_fill.sv
// constant block fill engine with busy flag and done pulse

`default_nettype none
`timescale 1ns/1ps

module blit_fill (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire logic               start_i,    // one-cycle start ignored while busy
    input  wire xv_pkg::blit_cmd_t  cmd_i,
    input  wire logic               ack_i,      // VRAM accepted write
    output logic                    sel_o,
    output xv_pkg::mem_req_t        req_o,
    output logic                    busy_o,
    output logic                    done_o      // cycle after last ack
);

typedef enum logic {
    IDLE,
    FILL
} state_e;

state_e         state;
xv_pkg::word_t  ptr;            // next address
xv_pkg::word_t  val;            // fill word
xv_pkg::word_t  remain;         // writes left including current

always_ff @(posedge clk) begin
    if (reset_i) begin
        state  <= IDLE;
        done_o <= 1'b0;
    end else begin
        done_o <= 1'b0;
        case (state)
            IDLE: if (start_i) begin
                if (cmd_i.count == '0) begin
                    done_o <= 1'b1;     // empty fill ends at once
                end else begin
                    state <= FILL;
                end
            end
            FILL: if (ack_i && remain == 16'd1) begin
                state  <= IDLE;
                done_o <= 1'b1;
            end
            default: state <= IDLE;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (state == IDLE && start_i) begin
        ptr    <= cmd_i.dst;
        val    <= cmd_i.val;
        remain <= cmd_i.count;
    end else if (state == FILL && ack_i) begin
        ptr    <= ptr + 16'd1;          // count up
        remain <= remain - 16'd1;
    end
end

assign sel_o  = (state == FILL);        // request held while filling
assign busy_o = (state == FILL);

always_comb begin
    req_o.wr   = 1'b1;                  // fill only writes
    req_o.addr = ptr;
    req_o.data = val;
end

endmodule

`default_nettype wire

//--- hw/intr_timer.sv
// one-shot compare timer, interrupt pending status and bus interrupt

`default_nettype none
`timescale 1ns/1ps

module intr_timer #(
    parameter int TIMER_DIV = 4             // clocks per tick
)(
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire logic               blit_done_i,    // fill finished
    input  wire xv_pkg::word_t      timer_cmp_i,    // ticks until timer source
    input  wire logic               timer_load_i,   // restart timer
    input  wire xv_pkg::intr_t      intr_mask_i,
    input  wire xv_pkg::intr_t      intr_clear_i,
    output xv_pkg::intr_t           intr_status_o,  // pending sources
    output logic                    bus_intr_o
);

localparam int DIV_W = (TIMER_DIV > 1) ? $clog2(TIMER_DIV) : 1;

logic [DIV_W-1:0]   div_cnt;        // prescaler
logic               tick;
xv_pkg::word_t      tick_cnt;
logic               armed;          // one shot pending
logic               timer_src;
xv_pkg::intr_t      src;

assign tick = (div_cnt == DIV_W'(TIMER_DIV - 1));

always_ff @(posedge clk) begin
    if (reset_i) begin
        div_cnt   <= '0;
        tick_cnt  <= '0;
        armed     <= 1'b0;
        timer_src <= 1'b0;
    end else begin
        timer_src <= 1'b0;
        if (timer_load_i) begin
            div_cnt  <= '0;             // restart from zero
            tick_cnt <= '0;
            armed    <= 1'b1;
        end else begin
            div_cnt <= tick ? '0 : div_cnt + 1'b1;
            if (tick) begin
                tick_cnt <= tick_cnt + 16'd1;
            end
            // compare*TIMER_DIV clocks after load
            if (armed && (timer_cmp_i == '0 ||
                          (tick && xv_pkg::word_t'(tick_cnt + 16'd1) == timer_cmp_i))) begin
                timer_src <= 1'b1;
                armed     <= 1'b0;
            end
        end
    end
end

always_comb begin
    src                     = '0;       // bits 2 and 3 stay 0
    src[xv_pkg::BLIT_INTR]  = blit_done_i;
    src[xv_pkg::TIMER_INTR] = timer_src;
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        intr_status_o <= '0;
        bus_intr_o    <= 1'b0;
    end else begin
        // only new, enabled, not yet pending sources interrupt the host
        bus_intr_o    <= |(src & intr_mask_i & ~intr_status_o);
        intr_status_o <= (intr_status_o | src) & ~intr_clear_i;
    end
end

endmodule

`default_nettype wire

//--- hw/reg_interface.sv
// host byte bus decode, VRAM address registers, read prefetch and status readback

`default_nettype none
`timescale 1ns/1ps

module reg_interface (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire logic               bus_cs_n_i,     // strobe, active low
    input  wire logic               bus_rd_nwr_i,   // 1 = read
    input  wire logic [3:0]         bus_reg_num_i,
    input  wire logic               bus_bytesel_i,  // 1 = odd byte
    input  wire logic [7:0]         bus_data_i,
    input  wire logic               mem_ack_i,      // one-cycle VRAM done
    input  wire xv_pkg::word_t      mem_rd_data_i,  // valid with ack
    input  wire logic               blit_busy_i,
    input  wire xv_pkg::intr_t      intr_status_i,
    output logic [7:0]              bus_data_o,     // registered read byte
    output logic                    mem_sel_o,
    output xv_pkg::mem_req_t        mem_req_o,
    output logic                    blit_start_o,   // one-cycle fill start
    output xv_pkg::blit_cmd_t       blit_cmd_o,
    output xv_pkg::intr_t           intr_mask_o,
    output xv_pkg::intr_t           intr_clear_o,   // one-cycle clear vector
    output xv_pkg::word_t           timer_cmp_o,
    output logic                    timer_load_o    // one-cycle reload
);

xv_pkg::xm_reg_e    reg_sel;        // decoded register number
logic               wr_strobe;      // any byte write this cycle
logic               rd_strobe;      // any byte read this cycle
logic               wr_commit;      // odd byte write with full word ready
logic               rd_step;        // odd byte read of data port
logic [7:0]         hi_byte;        // held even byte
xv_pkg::word_t      wr_word;        // word being committed

xv_pkg::word_t      wr_incr;
xv_pkg::word_t      wr_addr;
xv_pkg::word_t      rd_addr;
xv_pkg::word_t      rd_next;        // read pointer after step
xv_pkg::word_t      rd_data;        // prefetched VRAM word
xv_pkg::word_t      rd_word;        // readback mux
logic               mem_busy;

logic               req_issue;      // start a VRAM access
xv_pkg::mem_req_t   req_next;

assign reg_sel   = xv_pkg::xm_reg_e'(bus_reg_num_i);
assign wr_strobe = ~bus_cs_n_i & ~bus_rd_nwr_i;
assign rd_strobe = ~bus_cs_n_i & bus_rd_nwr_i;
assign wr_commit = wr_strobe & bus_bytesel_i;
assign rd_step   = rd_strobe & bus_bytesel_i & (reg_sel == xv_pkg::XM_DATA);
assign wr_word   = {hi_byte, bus_data_i};
assign rd_next   = rd_addr + wr_incr;
assign mem_busy  = mem_sel_o;       // outstanding until ack

// next host VRAM access with at most one per strobe
always_comb begin
    req_issue = 1'b0;
    req_next  = mem_req_o;
    if (wr_commit && reg_sel == xv_pkg::XM_DATA) begin
        req_issue     = 1'b1;
        req_next.wr   = 1'b1;
        req_next.addr = wr_addr;
        req_next.data = wr_word;
    end else if (wr_commit && reg_sel == xv_pkg::XM_RD_ADDR) begin
        req_issue     = 1'b1;       // prefetch at new pointer
        req_next.wr   = 1'b0;
        req_next.addr = wr_word;
        req_next.data = '0;
    end else if (rd_step) begin
        req_issue     = 1'b1;       // prefetch next word
        req_next.wr   = 1'b0;
        req_next.addr = rd_next;
        req_next.data = '0;
    end
end

// register readback
always_comb begin
    case (reg_sel)
        xv_pkg::XM_INT_CTRL:   rd_word = {4'b0, intr_mask_o, 4'b0, intr_status_i};
        xv_pkg::XM_WR_INCR:    rd_word = wr_incr;
        xv_pkg::XM_WR_ADDR:    rd_word = wr_addr;
        xv_pkg::XM_DATA:       rd_word = rd_data;
        xv_pkg::XM_RD_ADDR:    rd_word = rd_addr;
        xv_pkg::XM_BLIT_DST:   rd_word = blit_cmd_o.dst;
        xv_pkg::XM_BLIT_VAL:   rd_word = blit_cmd_o.val;
        xv_pkg::XM_BLIT_COUNT: rd_word = blit_cmd_o.count;
        xv_pkg::XM_TIMER:      rd_word = timer_cmp_o;
        xv_pkg::XM_SYS_CTRL:   rd_word = {14'b0, mem_busy, blit_busy_i};
        default:               rd_word = '0;
    endcase
end

// control state
always_ff @(posedge clk) begin
    if (reset_i) begin
        bus_data_o   <= '0;
        mem_sel_o    <= 1'b0;
        blit_start_o <= 1'b0;
        timer_load_o <= 1'b0;
        intr_mask_o  <= '0;
        intr_clear_o <= '0;
        wr_incr      <= '0;
        wr_addr      <= '0;
        rd_addr      <= '0;
    end else begin
        blit_start_o <= 1'b0;           // pulses last one cycle
        timer_load_o <= 1'b0;
        intr_clear_o <= '0;

        if (mem_ack_i) begin
            mem_sel_o <= 1'b0;
            if (mem_req_o.wr) begin
                wr_addr <= wr_addr + wr_incr;   // advance after write lands
            end
        end
        if (req_issue) begin
            mem_sel_o <= 1'b1;          // new request wins over ack drop
        end
        if (rd_step) begin
            rd_addr <= rd_next;
        end
        if (rd_strobe) begin
            bus_data_o <= bus_bytesel_i ? rd_word[7:0] : rd_word[15:8];
        end

        if (wr_commit) begin
            case (reg_sel)
                xv_pkg::XM_INT_CTRL: begin
                    intr_mask_o  <= wr_word[11:8];  // high byte
                    intr_clear_o <= wr_word[3:0];   // low byte clears
                end
                xv_pkg::XM_WR_INCR:    wr_incr      <= wr_word;
                xv_pkg::XM_WR_ADDR:    wr_addr      <= wr_word;  // overrides advance
                xv_pkg::XM_RD_ADDR:    rd_addr      <= wr_word;
                xv_pkg::XM_BLIT_COUNT: blit_start_o <= 1'b1;
                xv_pkg::XM_TIMER:      timer_load_o <= 1'b1;
                default: ;
            endcase
        end
    end
end

// data registers
always_ff @(posedge clk) begin
    if (wr_strobe && !bus_bytesel_i) begin
        hi_byte <= bus_data_i;
    end
    if (req_issue) begin
        mem_req_o <= req_next;
    end
    if (mem_ack_i && !mem_req_o.wr) begin
        rd_data <= mem_rd_data_i;       // prefetch lands
    end
    if (wr_commit) begin
        case (reg_sel)
            xv_pkg::XM_BLIT_DST:   blit_cmd_o.dst   <= wr_word;
            xv_pkg::XM_BLIT_VAL:   blit_cmd_o.val   <= wr_word;
            xv_pkg::XM_BLIT_COUNT: blit_cmd_o.count <= wr_word;
            xv_pkg::XM_TIMER:      timer_cmp_o      <= wr_word;
            default: ;
        endcase
    end
end

endmodule

`default_nettype wire

//--- hw/xv_top.sv
// top level wiring of host registers, fill unit, VRAM arbiter and interrupt block

`default_nettype none
`timescale 1ns/1ps

module xv_top #(
    parameter int VRAM_AW   = 10,   // VRAM address bits
    parameter int TIMER_DIV = 4     // clocks per timer tick
)(
    input  wire logic         clk,
    input  wire logic         reset_i,          // sync, active high
    input  wire logic         bus_cs_n_i,       // active low one-cycle select strobe
    input  wire logic         bus_rd_nwr_i,     // 1 = read, 0 = write
    input  wire logic [3:0]   bus_reg_num_i,    // register number
    input  wire logic         bus_bytesel_i,    // 0 = even (high) byte, 1 = odd (low) byte
    input  wire logic [7:0]   bus_data_i,
    output logic      [7:0]   bus_data_o,
    output logic              bus_intr_o        // interrupt to host
);

// host side memory port
logic                   host_sel;
logic                   host_ack;
xv_pkg::mem_req_t       host_req;
xv_pkg::word_t          vram_rd_data;       // shared read data

// fill unit
logic                   blit_sel;
logic                   blit_ack;
xv_pkg::mem_req_t       blit_req;
logic                   blit_start;
xv_pkg::blit_cmd_t      blit_cmd;
logic                   blit_busy;
logic                   blit_done;

// interrupts and timer
xv_pkg::intr_t          intr_mask;
xv_pkg::intr_t          intr_clear;
xv_pkg::intr_t          intr_status;
xv_pkg::word_t          timer_cmp;
logic                   timer_load;

reg_interface u_regs (
    .clk            (clk),
    .reset_i        (reset_i),
    .bus_cs_n_i     (bus_cs_n_i),
    .bus_rd_nwr_i   (bus_rd_nwr_i),
    .bus_reg_num_i  (bus_reg_num_i),
    .bus_bytesel_i  (bus_bytesel_i),
    .bus_data_i     (bus_data_i),
    .mem_ack_i      (host_ack),
    .mem_rd_data_i  (vram_rd_data),
    .blit_busy_i    (blit_busy),
    .intr_status_i  (intr_status),
    .bus_data_o     (bus_data_o),
    .mem_sel_o      (host_sel),
    .mem_req_o      (host_req),
    .blit_start_o   (blit_start),
    .blit_cmd_o     (blit_cmd),
    .intr_mask_o    (intr_mask),
    .intr_clear_o   (intr_clear),
    .timer_cmp_o    (timer_cmp),
    .timer_load_o   (timer_load)
);

blit_fill u_fill (
    .clk            (clk),
    .reset_i        (reset_i),
    .start_i        (blit_start),
    .cmd_i          (blit_cmd),
    .ack_i          (blit_ack),
    .sel_o          (blit_sel),
    .req_o          (blit_req),
    .busy_o         (blit_busy),
    .done_o         (blit_done)
);

vram_arb #(
    .VRAM_AW        (VRAM_AW)
) u_vram (
    .clk            (clk),
    .host_sel_i     (host_sel),
    .host_req_i     (host_req),
    .blit_sel_i     (blit_sel),
    .blit_req_i     (blit_req),
    .host_ack_o     (host_ack),
    .blit_ack_o     (blit_ack),
    .rd_data_o      (vram_rd_data)
);

intr_timer #(
    .TIMER_DIV      (TIMER_DIV)
) u_intr (
    .clk            (clk),
    .reset_i        (reset_i),
    .blit_done_i    (blit_done),
    .timer_cmp_i    (timer_cmp),
    .timer_load_i   (timer_load),
    .intr_mask_i    (intr_mask),
    .intr_clear_i   (intr_clear),
    .intr_status_o  (intr_status),
    .bus_intr_o     (bus_intr_o)
);

endmodule

`default_nettype wire

//--- sim/tb_xv_top.sv
// testbench driving the host byte bus through VRAM, fill and interrupt checks

`default_nettype none
`timescale 1ns/1ps

module tb_xv_top;

localparam int VRAM_AW = 10;
localparam int POLLS   = 200;           // per-wait poll limit

logic           clk;
logic           reset_i;
logic           bus_cs_n_i;
logic           bus_rd_nwr_i;
logic [3:0]     bus_reg_num_i;
logic           bus_bytesel_i;
logic [7:0]     bus_data_i;
logic [7:0]     bus_data_o;
logic           bus_intr_o;
int             intr_count;             // cycles with bus_intr_o high

xv_top #(.VRAM_AW(VRAM_AW), .TIMER_DIV(4)) dut0 (
    .clk            (clk),
    .reset_i        (reset_i),
    .bus_cs_n_i     (bus_cs_n_i),
    .bus_rd_nwr_i   (bus_rd_nwr_i),
    .bus_reg_num_i  (bus_reg_num_i),
    .bus_bytesel_i  (bus_bytesel_i),
    .bus_data_i     (bus_data_i),
    .bus_data_o     (bus_data_o),
    .bus_intr_o     (bus_intr_o)
);

always #50 clk = ~clk;                  // 100 ns period

always @(negedge clk) begin
    if (bus_intr_o) begin
        intr_count <= intr_count + 1;   // one-cycle pulses
    end
end

task automatic check(input string name, input logic [15:0] exp, input logic [15:0] act);
    assert (exp == act) else begin
        $display("ERROR %s: expected %h, actual %h", name, exp, act);
        $display("Checks failed");
        $fatal(1);
    end
endtask

task automatic timed_out(input string what);
    $display("timeout while waiting for %s", what);
    $display("Checks failed");
    $fatal(1);
endtask

// all bus tasks start and end on a falling edge
task automatic bus_write(input xv_pkg::xm_reg_e r, input xv_pkg::word_t w);
    bus_cs_n_i    = 1'b0;
    bus_rd_nwr_i  = 1'b0;
    bus_reg_num_i = r;
    bus_bytesel_i = 1'b0;               // even byte first carries the high half
    bus_data_i    = w[15:8];
    @(negedge clk);
    bus_bytesel_i = 1'b1;               // odd byte commits
    bus_data_i    = w[7:0];
    @(negedge clk);
    bus_cs_n_i    = 1'b1;
endtask

task automatic read_byte(input xv_pkg::xm_reg_e r, input logic odd, output logic [7:0] b);
    bus_cs_n_i    = 1'b0;
    bus_rd_nwr_i  = 1'b1;
    bus_reg_num_i = r;
    bus_bytesel_i = odd;
    @(negedge clk);
    bus_cs_n_i    = 1'b1;
    b             = bus_data_o;         // registered on the edge in between
endtask

task automatic read_reg(input xv_pkg::xm_reg_e r, output xv_pkg::word_t w);
    logic [7:0] hi;
    logic [7:0] lo;
    read_byte(r, 1'b0, hi);
    read_byte(r, 1'b1, lo);
    w = {hi, lo};
endtask

// poll sys ctrl until the chosen busy bit drops
task automatic wait_idle(input int bit_idx, input string what);
    logic [7:0] b;
    logic       done;
    done = 1'b0;
    for (int i = 0; i < POLLS && !done; i++) begin
        read_byte(xv_pkg::XM_SYS_CTRL, 1'b1, b);
        done = !b[bit_idx];
    end
    if (!done) begin
        timed_out(what);
    end
endtask

task automatic wait_status(input int bit_idx);
    logic [7:0] b;
    logic       done;
    done = 1'b0;
    for (int i = 0; i < POLLS && !done; i++) begin
        read_byte(xv_pkg::XM_INT_CTRL, 1'b1, b);
        done = b[bit_idx];
    end
    if (!done) begin
        timed_out("interrupt status bit");
    end
endtask

task automatic write_vram(input xv_pkg::word_t w);
    bus_write(xv_pkg::XM_DATA, w);
    wait_idle(1, "host write ack");
endtask

task automatic set_read_addr(input xv_pkg::word_t a);
    bus_write(xv_pkg::XM_RD_ADDR, a);
    wait_idle(1, "prefetch ack");
endtask

task automatic read_vram(output xv_pkg::word_t w);
    read_reg(xv_pkg::XM_DATA, w);       // odd byte steps and prefetches
    wait_idle(1, "prefetch ack");
endtask

task automatic run_fill(input xv_pkg::word_t dst, input xv_pkg::word_t val,
                        input xv_pkg::word_t len);
    logic [7:0] b;
    bus_write(xv_pkg::XM_BLIT_DST, dst);
    bus_write(xv_pkg::XM_BLIT_VAL, val);
    bus_write(xv_pkg::XM_BLIT_COUNT, len);
    @(negedge clk);                     // busy rises the cycle after start
    read_byte(xv_pkg::XM_SYS_CTRL, 1'b1, b);
    check("fill busy", 16'd1, {15'd0, b[0]});
    wait_idle(0, "fill done");
    repeat (2) @(negedge clk);          // let the interrupt pulse pass
endtask

initial begin
    int             base;
    xv_pkg::word_t  exp_words[8];
    xv_pkg::word_t  w;
    xv_pkg::word_t  val;
    xv_pkg::word_t  len;
    xv_pkg::word_t  dst;

    clk = 1'b0;
    reset_i = 1'b1;
    bus_cs_n_i = 1'b1;
    bus_rd_nwr_i = 1'b1;
    bus_reg_num_i = '0;
    bus_bytesel_i = 1'b0;
    bus_data_i = '0;
    intr_count = 0;
    void'($urandom(11421));             // seed once
    repeat (10) @(negedge clk);
    reset_i = 1'b0;

    // write and read back
    bus_write(xv_pkg::XM_WR_INCR, 16'd1);
    bus_write(xv_pkg::XM_WR_ADDR, 16'h0100);
    for (int i = 0; i < 8; i++) begin
        exp_words[i] = xv_pkg::word_t'($urandom);
        write_vram(exp_words[i]);
    end
    set_read_addr(16'h0100);
    for (int i = 0; i < 8; i++) begin
        read_vram(w);
        check("readback", exp_words[i], w);
    end

    // increment 3 and address wrap
    bus_write(xv_pkg::XM_WR_INCR, 16'd3);
    read_reg(xv_pkg::XM_WR_INCR, w);
    check("wr_incr readback", 16'd3, w);
    bus_write(xv_pkg::XM_WR_ADDR, 16'((1 << VRAM_AW) + 5));
    read_reg(xv_pkg::XM_WR_ADDR, w);
    check("wr_addr readback", 16'((1 << VRAM_AW) + 5), w);
    val = xv_pkg::word_t'($urandom);
    write_vram(val);
    read_reg(xv_pkg::XM_WR_ADDR, w);
    check("wr_addr advance", 16'((1 << VRAM_AW) + 8), w);
    set_read_addr(16'd5);
    read_vram(w);
    check("wrapped word", val, w);

    // fill with a marker word just past the range
    dst = 16'h0200;
    len = xv_pkg::word_t'(1 + $urandom % 16);
    val = xv_pkg::word_t'($urandom);
    bus_write(xv_pkg::XM_WR_INCR, 16'd1);
    bus_write(xv_pkg::XM_WR_ADDR, dst + len);
    write_vram(~val);
    run_fill(dst, val, len);
    set_read_addr(dst);
    for (int i = 0; i < len; i++) begin
        read_vram(w);
        check("fill word", val, w);
    end
    read_vram(w);
    check("word past fill", ~val, w);

    // fill interrupt with blit bit masked in and stale status cleared
    bus_write(xv_pkg::XM_INT_CTRL, 16'h010F);
    base = intr_count;
    run_fill(16'h0300, xv_pkg::word_t'($urandom), 16'd4);
    check("fill intr pulse", 16'(base + 1), 16'(intr_count));
    read_reg(xv_pkg::XM_INT_CTRL, w);
    check("fill status", 16'h0101, w);
    run_fill(16'h0310, xv_pkg::word_t'($urandom), 16'd3);
    check("pending fill no intr", 16'(base + 1), 16'(intr_count));
    bus_write(xv_pkg::XM_INT_CTRL, 16'h0101);
    read_reg(xv_pkg::XM_INT_CTRL, w);
    check("status after clear", 16'h0100, w);

    // timer source masked off
    bus_write(xv_pkg::XM_INT_CTRL, 16'h0003);
    base = intr_count;
    bus_write(xv_pkg::XM_TIMER, 16'd5);       // 20 clocks
    wait_status(xv_pkg::TIMER_INTR);
    repeat (2) @(negedge clk);
    check("masked timer no intr", 16'(base), 16'(intr_count));
    read_reg(xv_pkg::XM_INT_CTRL, w);
    check("timer status", 16'h0002, w);

    // timer unmasked and cleared then reloaded
    bus_write(xv_pkg::XM_INT_CTRL, 16'h0202);
    read_reg(xv_pkg::XM_INT_CTRL, w);
    check("timer cleared", 16'h0200, w);
    bus_write(xv_pkg::XM_TIMER, 16'd5);
    wait_status(xv_pkg::TIMER_INTR);
    repeat (2) @(negedge clk);
    check("timer intr pulse", 16'(base + 1), 16'(intr_count));

    $display("All checks passed");
    $finish;
end

endmodule

`default_nettype wire

//--- sim.f
hw/xv_pkg.sv
hw/vram_arb.sv
hw/blit_fill.sv
hw/intr_timer.sv
hw/reg_interface.sv
hw/xv_top.sv
sim/tb_xv_top.sv
